// ==== src/stream_pkg.sv ====
package stream_pkg;

   //----------------------------------------------------------------------
   // Sizes
   //----------------------------------------------------------------------
   localparam int DATA_W  = 8;              // Sample width
   localparam int ADDR_W  = 4;              // Buffer address width
   localparam int DEPTH   = 1 << ADDR_W;    // Words in the buffer
   localparam int CREDITS = 4;              // Receiver credits after reset
   localparam int CNT_W   = 3;              // Credit counter, holds CREDITS
   localparam int PASS_W  = 8;              // Pass counter, wraps
   localparam int OP_W    = 3;              // Opcode field

   // Highest address, wrap point of both pointers
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

   //----------------------------------------------------------------------
   // Command opcodes
   //----------------------------------------------------------------------
   typedef enum logic [OP_W-1:0] {
      OP_NOP   = 3'd0,  // No effect
      OP_ONCE  = 3'd1,  // One pass, ends at DEPTH-1
      OP_LOOP  = 3'd2,  // Passes until halted
      OP_HALT  = 3'd3,  // Stop issuing, in-flight words still delivered
      OP_CLEAR = 3'd4   // Write pointer back to 0
   } stream_op_e;

   //----------------------------------------------------------------------
   // Controller states
   //----------------------------------------------------------------------
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,   // Writes accepted, no reads
      ST_ONCE = 2'd1,   // Single pass in progress
      ST_LOOP = 2'd2    // Continuous streaming
   } stream_state_e;

   // Output word, data plus framing
   typedef struct packed {
      logic [DATA_W-1:0] data;  // Sample
      logic              last;  // Final word of a pass
      logic [PASS_W-1:0] pass;  // Completed passes so far
   } stream_word_t;

endpackage

// ==== src/stream_addr_gen.sv ====
module stream_addr_gen (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          inc_i,     // Advance by one
   input  logic                          clear_i,   // Back to 0, beats inc_i
   output logic [stream_pkg::ADDR_W-1:0] addr_o,
   output logic                          at_end_o   // Sitting on DEPTH-1
);
   import stream_pkg::*;

   logic [ADDR_W-1:0] addr_q;
   logic [ADDR_W-1:0] addr_next;
   logic              wrap;

   //----------------------------------------------------------------------
   // Next address
   //----------------------------------------------------------------------
   // End of buffer, next step goes to 0
   assign wrap = (addr_q == LAST_ADDR);

   always_comb begin
      if (wrap) begin
         addr_next = '0;                       // Wrap to start
      end else begin
         addr_next = addr_q + 1'b1;            // Plain step
      end
   end

   //----------------------------------------------------------------------
   // Address register
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         addr_q <= '0;
      end else if (clear_i) begin
         // Clear overrides any increment in the same cycle
         addr_q <= '0;
      end else if (inc_i) begin
         addr_q <= addr_next;
      end
   end

   // Outputs
   assign addr_o   = addr_q;
   assign at_end_o = wrap;   // Same compare as the wrap

   // The flag is combinational from the register, so a caller sees it in
   // the same cycle it issues the address at DEPTH-1. That lets the
   // controller tag the issue as last without an extra cycle of latency.
   // Both pointers of the design use this block, the write pointer
   // through clear_i and the read pointer through inc_i only.

endmodule

// ==== src/sample_ram.sv ====
module sample_ram (
   input  logic                          clk_i,
   // Write port
   input  logic                          we_i,
   input  logic [stream_pkg::ADDR_W-1:0] waddr_i,
   input  logic [stream_pkg::DATA_W-1:0] wdata_i,
   // Read port, one cycle latency
   input  logic                          re_i,
   input  logic [stream_pkg::ADDR_W-1:0] raddr_i,
   output logic [stream_pkg::DATA_W-1:0] rdata_o
);
   import stream_pkg::*;

   logic [DATA_W-1:0] mem [DEPTH];   // Sample storage
   logic [DATA_W-1:0] rdata_q;       // Read register

   //----------------------------------------------------------------------
   // Write port
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   //----------------------------------------------------------------------
   // Registered read
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (re_i) begin
         rdata_q <= mem[raddr_i];    // Holds between reads
      end
   end

   assign rdata_o = rdata_q;

   // Writes only happen while idle and reads only while streaming, so
   // the two ports never touch the same word in the same cycle and the
   // read-during-write behaviour of the target memory does not matter.

endmodule

// ==== src/stream_ctrl.sv ====
module stream_ctrl (
   input  logic                   clk_i,
   input  logic                   rst_i,
   // Host side
   input  logic                   wr_valid_i,    // Write strobe
   input  logic                   cmd_valid_i,   // Command strobe
   input  stream_pkg::stream_op_e cmd_op_i,
   // Receiver side
   input  logic                   credit_i,      // One credit back
   // Read pointer status
   input  logic                   rd_at_end_i,
   // Write pointer and RAM write
   output logic                   wr_we_o,
   output logic                   wr_inc_o,
   output logic                   wr_clear_o,
   // Read issue
   output logic                   issue_o,       // RAM read enable and pointer step
   output logic                   issue_last_o   // Issue hits DEPTH-1
);
   import stream_pkg::*;

   stream_state_e    state_q;
   stream_state_e    state_d;
   logic [CNT_W-1:0] credit_q;      // Credits still held
   logic             streaming;
   logic             have_credit;
   logic             wr_ok;
   logic             cmd_once;
   logic             cmd_loop;
   logic             cmd_halt;
   logic             cmd_clear;

   //----------------------------------------------------------------------
   // Command decode
   //----------------------------------------------------------------------
   assign cmd_once  = cmd_valid_i && (cmd_op_i == OP_ONCE);
   assign cmd_loop  = cmd_valid_i && (cmd_op_i == OP_LOOP);
   assign cmd_halt  = cmd_valid_i && (cmd_op_i == OP_HALT);
   assign cmd_clear = cmd_valid_i && (cmd_op_i == OP_CLEAR);
   // OP_NOP falls through every compare

   //----------------------------------------------------------------------
   // Write gating
   //----------------------------------------------------------------------
   // Writes only land while idle, dropped otherwise
   assign wr_ok      = wr_valid_i && (state_q == ST_IDLE);
   assign wr_we_o    = wr_ok;
   assign wr_inc_o   = wr_ok;       // Pointer steps on the same edge
   assign wr_clear_o = cmd_clear;

   //----------------------------------------------------------------------
   // Read issue
   //----------------------------------------------------------------------
   assign streaming    = (state_q != ST_IDLE);
   assign have_credit  = (credit_q != '0);
   assign issue_o      = streaming && have_credit;   // No stall after issue
   assign issue_last_o = issue_o && rd_at_end_i;     // Closes the pass

   //----------------------------------------------------------------------
   // State machine
   //----------------------------------------------------------------------
   always_comb begin
      state_d = state_q;

      // Single pass ends on the issue of DEPTH-1
      if ((state_q == ST_ONCE) && issue_last_o) begin
         state_d = ST_IDLE;
      end

      // Commands win over the end of pass
      if (cmd_halt) begin
         state_d = ST_IDLE;          // Read pointer keeps position
      end else if (cmd_once) begin
         state_d = ST_ONCE;
      end else if (cmd_loop) begin
         state_d = ST_LOOP;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   //----------------------------------------------------------------------
   // Credit counter
   //----------------------------------------------------------------------
   // Issue costs one, return gives one, both together cancel
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         credit_q <= CNT_W'(CREDITS);   // Receiver window
      end else if (issue_o && !credit_i) begin
         credit_q <= credit_q - 1'b1;
      end else if (credit_i && !issue_o) begin
         credit_q <= credit_q + 1'b1;
      end
   end

   // The receiver never hands back more than it was sent, so the counter
   // stays within 0..CREDITS and at most CREDITS words are unacknowledged.
   // Once a read issues, the RAM and the framer carry it to the output
   // in two cycles without any further handshake.

endmodule

// ==== src/stream_framer.sv ====
module stream_framer (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          issue_i,        // Read issued this cycle
   input  logic                          issue_last_i,   // Issue closes a pass
   input  logic [stream_pkg::DATA_W-1:0] rd_data_i,      // RAM data, one cycle late
   output logic                          out_valid_o,
   output stream_pkg::stream_word_t      out_word_o
);
   import stream_pkg::*;

   logic              valid_q;     // Issue, aligned with RAM data
   logic              last_q;      // Last flag, aligned with RAM data
   logic [PASS_W-1:0] pass_q;      // Passes completed so far
   logic              out_valid_q;
   stream_word_t      word_q;

   //----------------------------------------------------------------------
   // Stage 1, match the RAM read latency
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
         last_q  <= 1'b0;
      end else begin
         valid_q <= issue_i;
         last_q  <= issue_i && issue_last_i;
      end
   end

   //----------------------------------------------------------------------
   // Stage 2, output register
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= valid_q;
      end
   end

   // Payload only, loaded with each word
   always_ff @(posedge clk_i) begin
      if (valid_q) begin
         word_q.data <= rd_data_i;
         word_q.last <= last_q;
         word_q.pass <= pass_q;     // Count before this word's last
      end
   end

   //----------------------------------------------------------------------
   // Pass counter
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pass_q <= '0;
      end else if (valid_q && last_q) begin
         pass_q <= pass_q + 1'b1;   // Wraps at 2**PASS_W
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_word_o  = word_q;

endmodule

// ==== src/stream_top.sv ====
module stream_top (
   input  logic                          clk_i,
   input  logic                          rst_i,
   // Host write port, no back-pressure
   input  logic                          wr_valid_i,
   input  logic [stream_pkg::DATA_W-1:0] wr_data_i,
   // Host command port
   input  logic                          cmd_valid_i,
   input  stream_pkg::stream_op_e        cmd_op_i,
   // Output stream, credit flow control
   input  logic                          credit_i,
   output logic                          out_valid_o,
   output stream_pkg::stream_word_t      out_word_o
);
   import stream_pkg::*;

   logic              wr_we;
   logic              wr_inc;
   logic              wr_clear;
   logic [ADDR_W-1:0] wr_addr;
   logic              issue;
   logic              issue_last;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_at_end;
   logic [DATA_W-1:0] rd_data;

   //----------------------------------------------------------------------
   // Control
   //----------------------------------------------------------------------
   stream_ctrl ctrl_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .wr_valid_i   (wr_valid_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_op_i     (cmd_op_i),
      .credit_i     (credit_i),
      .rd_at_end_i  (rd_at_end),
      .wr_we_o      (wr_we),
      .wr_inc_o     (wr_inc),
      .wr_clear_o   (wr_clear),
      .issue_o      (issue),
      .issue_last_o (issue_last)
   );

   //----------------------------------------------------------------------
   // Datapath
   //----------------------------------------------------------------------
   stream_addr_gen wr_addr_i (      // Write pointer, end flag not needed
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .inc_i    (wr_inc),
      .clear_i  (wr_clear),
      .addr_o   (wr_addr),
      .at_end_o ()
   );

   stream_addr_gen rd_addr_i (      // Read pointer, never cleared
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .inc_i    (issue),
      .clear_i  (1'b0),
      .addr_o   (rd_addr),
      .at_end_o (rd_at_end)
   );

   sample_ram ram_i (
      .clk_i   (clk_i),
      .we_i    (wr_we),
      .waddr_i (wr_addr),
      .wdata_i (wr_data_i),
      .re_i    (issue),
      .raddr_i (rd_addr),
      .rdata_o (rd_data)
   );

   stream_framer framer_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .issue_i      (issue),
      .issue_last_i (issue_last),
      .rd_data_i    (rd_data),
      .out_valid_o  (out_valid_o),
      .out_word_o   (out_word_o)
   );

endmodule

// ==== sim/tb_stream_top.sv ====
module tb_stream_top;
   import stream_pkg::*;

   // Step kinds of the stimulus table
   typedef enum logic [2:0] {
      S_WRITE,   // One host write, val is the data
      S_CMD,     // One command, val is the opcode
      S_WAIT,    // Wait for val more output words
      S_LAST,    // Wait for the next word with last set
      S_QUIET,   // val cycles with no output word allowed
      S_HOLD     // Receiver holds credits back while val is 1
   } step_kind_e;

   typedef struct packed {
      step_kind_e  kind;
      logic [15:0] val;
   } step_t;

   logic              clk_i;
   logic              rst_i;
   logic              wr_valid_i;
   logic [DATA_W-1:0] wr_data_i;
   logic              cmd_valid_i;
   stream_op_e        cmd_op_i;
   logic              credit_i;
   logic              out_valid_o;
   stream_word_t      out_word_o;

   step_t             steps[$];                  // Stimulus table
   integer            seed = 32'h5026;
   integer            errors = 0;
   logic              table_ready = 1'b0;

   // Receiver and memory model
   logic [DATA_W-1:0] mem_m [DEPTH];
   logic [ADDR_W-1:0] wr_ptr_m = '0;
   logic [ADDR_W-1:0] rd_ptr_m = '0;              // Next address expected out
   logic [PASS_W-1:0] pass_m = '0;
   stream_state_e     mdl_state = ST_IDLE;
   int                rx_count = 0;               // Words received
   int                last_count = 0;             // Words with last received
   int                owed = 0;                   // Credits not yet returned
   int                delay_cnt = 0;
   logic              hold_credits;

   stream_top dut_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .wr_valid_i  (wr_valid_i),
      .wr_data_i   (wr_data_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_op_i    (cmd_op_i),
      .credit_i    (credit_i),
      .out_valid_o (out_valid_o),
      .out_word_o  (out_word_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   //----------------------------------------------------------------------
   // Table
   //----------------------------------------------------------------------
   function automatic void add_step(step_kind_e kind, int val);
      steps.push_back('{kind, val[15:0]});
   endfunction

   function automatic void build_table();
      integer r;
      for (int i = 0; i < DEPTH; i++) begin        // Fill the whole buffer
         r = $random(seed);
         add_step(S_WRITE, r[DATA_W-1:0]);
      end
      add_step(S_CMD, OP_ONCE);                    // One full pass
      add_step(S_WAIT, DEPTH);
      add_step(S_QUIET, 20);                       // Long enough for all credits back
      add_step(S_HOLD, 1);                         // Credit window only
      add_step(S_CMD, OP_ONCE);
      add_step(S_WAIT, CREDITS);
      add_step(S_QUIET, 10);
      add_step(S_HOLD, 0);
      add_step(S_LAST, 0);
      add_step(S_QUIET, 12);
      add_step(S_CMD, OP_LOOP);                    // Loop across the wrap
      add_step(S_WAIT, 6);
      add_step(S_WRITE, 8'hEE);                    // Dropped, streaming
      add_step(S_WAIT, 30);
      add_step(S_CMD, OP_HALT);
      add_step(S_QUIET, 8);
      add_step(S_CMD, OP_ONCE);                    // Resume at read pointer
      add_step(S_LAST, 0);
      add_step(S_QUIET, 12);
      add_step(S_WRITE, 8'hA0);                    // Moves the write pointer off 0
      add_step(S_WRITE, 8'hA1);
      add_step(S_CMD, OP_CLEAR);                   // Rewrite from address 0
      for (int i = 0; i < 4; i++) begin
         add_step(S_WRITE, 8'h30 + i);
      end
      add_step(S_CMD, OP_ONCE);
      add_step(S_LAST, 0);
      add_step(S_QUIET, 12);
   endfunction

   //----------------------------------------------------------------------
   // Host side tasks
   //----------------------------------------------------------------------
   task automatic apply_write(input logic [DATA_W-1:0] data);
      @(posedge clk_i);
      wr_valid_i <= 1'b1;
      wr_data_i  <= data;
      if (mdl_state == ST_IDLE) begin              // Only lands while idle
         mem_m[wr_ptr_m] = data;
         wr_ptr_m        = wr_ptr_m + 1'b1;
      end
      @(posedge clk_i);
      wr_valid_i <= 1'b0;
   endtask

   task automatic apply_cmd(input stream_op_e op);
      int snap;
      @(posedge clk_i);
      cmd_valid_i <= 1'b1;
      cmd_op_i    <= op;
      @(posedge clk_i);                            // Sampled here
      cmd_valid_i <= 1'b0;
      cmd_op_i    <= OP_NOP;
      case (op)
         OP_ONCE:  mdl_state = ST_ONCE;
         OP_LOOP:  mdl_state = ST_LOOP;
         OP_HALT:  mdl_state = ST_IDLE;
         OP_CLEAR: wr_ptr_m  = '0;
         default:  ;
      endcase
      if (op == OP_HALT) begin
         snap = rx_count;                          // Words out before the halt edge
         repeat (8) @(posedge clk_i);
         assert (rx_count - snap <= 2) else begin
            errors = errors + 1;
            $display("Too many words after halt, %0d arrived", rx_count - snap);
         end
      end
   endtask

   task automatic wait_words(input int n);
      int target;
      target = rx_count + n;
      while (rx_count < target) @(posedge clk_i);
   endtask

   task automatic wait_last();
      int target;
      target = last_count + 1;
      while (last_count < target) @(posedge clk_i);
   endtask

   task automatic expect_quiet(input int n);
      int snap;
      snap = rx_count;
      repeat (n) @(posedge clk_i);
      assert (rx_count == snap) else begin
         errors = errors + 1;
         $display("Output kept streaming, %0d words arrived while quiet", rx_count - snap);
      end
   endtask

   task automatic run_step(input step_t s);
      case (s.kind)
         S_WRITE: apply_write(s.val[DATA_W-1:0]);
         S_CMD:   apply_cmd(stream_op_e'(s.val[OP_W-1:0]));
         S_WAIT:  wait_words(s.val);
         S_LAST:  wait_last();
         S_QUIET: expect_quiet(s.val);
         S_HOLD:  hold_credits <= s.val[0];        // Seen from the next edge
         default: ;
      endcase
   endtask

   //----------------------------------------------------------------------
   // Receiver, checker and credit return
   //----------------------------------------------------------------------
   task automatic check_word(input stream_word_t w);
      logic [DATA_W-1:0] exp_data;
      logic              exp_last;
      exp_data = mem_m[rd_ptr_m];
      exp_last = (rd_ptr_m == ADDR_W'(DEPTH - 1)); // Pass closes at the top
      assert (w.data == exp_data) else begin
         errors = errors + 1;
         $display("ERROR out_word_o.data: got %h expected %h", w.data, exp_data);
      end
      assert (w.last == exp_last) else begin
         errors = errors + 1;
         $display("ERROR out_word_o.last: got %h expected %h", w.last, exp_last);
      end
      assert (w.pass == pass_m) else begin
         errors = errors + 1;
         $display("ERROR out_word_o.pass: got %h expected %h", w.pass, pass_m);
      end
      if (exp_last) begin
         pass_m     = pass_m + 1'b1;
         last_count = last_count + 1;
         if (mdl_state == ST_ONCE) mdl_state = ST_IDLE;
      end
      rd_ptr_m = rd_ptr_m + 1'b1;
      rx_count = rx_count + 1;
      owed     = owed + 1;
      assert (owed <= CREDITS) else begin
         errors = errors + 1;
         $display("Receiver holds %0d unacknowledged words, over the credit limit", owed);
      end
   endtask

   always @(negedge clk_i) begin                   // Outputs settled mid cycle
      if (!rst_i && out_valid_o) check_word(out_word_o);
   end

   always @(posedge clk_i) begin
      credit_i <= 1'b0;
      if (!rst_i && !hold_credits && owed > 0) begin
         if (delay_cnt == 0) begin
            credit_i  <= 1'b1;                     // One credit per cycle at most
            owed      = owed - 1;
            delay_cnt = $random(seed) & 3;         // 0 to 3 cycles to the next
         end else begin
            delay_cnt = delay_cnt - 1;
         end
      end
   end

   //----------------------------------------------------------------------
   // Main sequence and watchdog
   //----------------------------------------------------------------------
   initial begin
      rst_i        = 1'b1;
      wr_valid_i   = 1'b0;
      wr_data_i    = '0;
      cmd_valid_i  = 1'b0;
      cmd_op_i     = OP_NOP;
      credit_i     = 1'b0;
      hold_credits = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      foreach (steps[i]) run_step(steps[i]);
      repeat (4) @(posedge clk_i);
      $display("Words checked %0d, errors %0d", rx_count, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      int words;
      int budget;
      wait (table_ready);
      words = 0;
      foreach (steps[i]) begin
         case (steps[i].kind)
            S_WRITE: words = words + 1;
            S_CMD:   words = words + 8;            // Halt settling time
            S_WAIT:  words = words + steps[i].val;
            S_LAST:  words = words + DEPTH;
            S_QUIET: words = words + steps[i].val;
            default: ;
         endcase
      end
      budget = words * 20 + 100;
      repeat (budget) @(posedge clk_i);
      $display("Watchdog expired after %0d cycles, run did not finish", budget);
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== all.f ====
src/stream_pkg.sv
src/stream_addr_gen.sv
src/sample_ram.sv
src/stream_ctrl.sv
src/stream_framer.sv
src/stream_top.sv
sim/tb_stream_top.sv
